/* filelist.f */
+incdir+include
verilog/hostPkg.sv
verilog/sramPkg.sv
verilog/rxWordAssembler.sv
verilog/wordFifo.sv
verilog/blockWriter.sv
verilog/txWordSerializer.sv
verilog/memCtrlTop.sv
sim/memCtrlTb.sv

/* sim/memCtrlTb.sv */
`timescale 1ns/1ps

`include "memCtrl_consts.svh"

module memCtrlTb;
  import hostPkg::*;
  import sramPkg::*;

  typedef struct packed {
    hostWord    tag;
    hostWord    count;      // vertex count, vertex tag only
    hostWord    start;      // start address word
    logic [4:0] size;       // data words before the stop address
    logic       goodClose;  // closing word is TAG_FINAL
    logic       finalWrite; // closing word lands in sram
    logic       junk;       // error byte and unknown tag first
  } cmdEntry;

  localparam int numCmds = 7;

  localparam cmdEntry cmdTable [numCmds] = '{
    '{`TAG_CAM,     16'd0, 16'h0100, 5'd5,  1'b1, 1'b1, 1'b0},
    '{`TAG_VRTX,    16'd2, 16'h0200, 5'd7,  1'b1, 1'b1, 1'b0},
    '{`TAG_TMATRIX, 16'd0, 16'h0300, 5'd12, 1'b1, 1'b0, 1'b0},
    '{`TAG_CLS_OBJ, 16'd0, 16'h0400, 5'd1,  1'b1, 1'b0, 1'b0},
    '{`TAG_REQUEST, 16'd0, 16'h0500, 5'd2,  1'b0, 1'b0, 1'b0},
    '{`TAG_OBJ,     16'd0, 16'h0600, 5'd14, 1'b1, 1'b1, 1'b0},
    '{`TAG_CAM,     16'd0, 16'hFFFC, 5'd5,  1'b1, 1'b1, 1'b1}
  };
  string cmdName [numCmds] = '{"camera", "vertex", "matrix", "closeObj",
                               "initBadClose", "object", "cameraAfterJunk"};

  logic        iClock;
  logic        rst;
  uartByte     rxByte;
  logic        rxReady;
  logic        rxError;
  uartByte     txByte;
  logic        txReady;
  logic        txSent;
  sramWriteReq sramReq;
  logic        sramWrite;
  logic        sramAck;

  hostWord     replyQ [$];     // reply words seen on the uart
  sramAddr     writeAddrQ [$]; // sram writes in order
  hostWord     writeDataQ [$];
  logic [31:0] sendRand = 32'd17662;
  logic [31:0] sramRand = 32'd17662 ^ 32'h0000_9E37;
  logic [31:0] txRand   = 32'd17662 ^ 32'h0000_5A5A;
  int          errors   = 0;
  int          timeouts = 0;

  memCtrlTop memCtrlTop_inst (
    .iClock, .rst, .rxByte, .rxReady, .rxError, .txByte, .txReady, .txSent,
    .sramReq, .sramWrite, .sramAck
  );

  initial begin
    iClock = 1'b0;
    forever #10 iClock = ~iClock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic checkWord(input string name, input hostWord exp, input hostWord act);
    if (act !== exp) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic checkAddr(input string name, input sramAddr exp, input sramAddr act);
    if (act !== exp) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // uart and sram models
  //////////////////////////////

  task automatic sendByte(input uartByte b, input logic err);
    int gap;
    sendRand = xorshift(sendRand);
    gap = 3 + int'(sendRand % 4); // keeps the queue from overflowing
    repeat (gap) @(posedge iClock);
    rxByte  <= b;
    rxError <= err;
    rxReady <= 1'b1;
    @(posedge iClock);
    rxReady <= 1'b0;
    rxError <= 1'b0;
  endtask

  task automatic sendWord(input hostWord w);
    sendByte(w[15:8], 1'b0); // high byte first
    sendByte(w[7:0], 1'b0);
  endtask

  initial begin : sramModel
    int delay;
    forever begin
      @(posedge iClock);
      if (sramWrite === 1'b1) begin
        writeAddrQ.push_back(sramReq.addr);
        writeDataQ.push_back(sramReq.data);
        sramRand = xorshift(sramRand);
        delay = 1 + int'(sramRand % 4);
        repeat (delay - 1) @(posedge iClock);
        sramAck <= 1'b1;
        @(posedge iClock);
        sramAck <= 1'b0;
      end
    end
  end

  initial begin : txModel
    int      delay;
    uartByte highByte;
    logic    haveHigh;
    haveHigh = 1'b0;
    forever begin
      @(posedge iClock);
      if (txReady === 1'b1) begin
        if (!haveHigh) begin
          highByte = txByte;
          haveHigh = 1'b1;
        end else begin
          replyQ.push_back({highByte, txByte});
          haveHigh = 1'b0;
        end
        txRand = xorshift(txRand);
        delay = 1 + int'(txRand % 4);
        repeat (delay - 1) @(posedge iClock);
        txSent <= 1'b1;
        @(posedge iClock);
        txSent <= 1'b0;
      end
    end
  end

  task automatic waitReplies(input int want);
    int cycles;
    cycles = 0;
    while (replyQ.size() < want && cycles < 2000) begin
      @(posedge iClock);
      cycles++;
    end
    if (replyQ.size() < want) begin
      $display("timeout: only %0d of %0d reply words arrived", replyQ.size(), want);
      timeouts++;
    end
  endtask

  //////////////////////////////
  // one table row
  //////////////////////////////

  task automatic runCommand(input int idx);
    cmdEntry e;
    hostWord dataQ [$];
    hostWord w;
    int      nWrites;
    e = cmdTable[idx];
    replyQ.delete();
    writeAddrQ.delete();
    writeDataQ.delete();
    if (e.junk) begin
      sendByte(8'hBB, 1'b0);
      sendByte(8'hBB, 1'b1); // dropped instead of forming BBBB
      sendWord(16'h1234);    // unknown tag
    end
    sendWord(e.tag);
    if (e.tag == `TAG_VRTX) sendWord(e.count);
    sendWord(e.start);
    for (int i = 0; i < e.size; i++) begin
      sendRand = xorshift(sendRand);
      w = sendRand[15:0];
      dataQ.push_back(w);
      sendWord(w);
    end
    sendWord(e.goodClose ? `TAG_FINAL : 16'h7E7E);
    waitReplies(2);
    repeat (30) @(posedge iClock); // room for any stray write or reply
    if (replyQ.size() != 2) begin
      $display("Error %s replies: expected 2 actual %0d", cmdName[idx], replyQ.size());
      errors++;
    end else begin
      checkWord({cmdName[idx], " ack"}, ~e.tag, replyQ[0]);
      checkWord({cmdName[idx], " end"}, e.goodClose ? e.tag : `TAG_ERROR, replyQ[1]);
    end
    nWrites = int'(e.size) + int'(e.finalWrite);
    if (writeAddrQ.size() != nWrites) begin
      $display("Error %s writes: expected %0d actual %0d", cmdName[idx], nWrites,
               writeAddrQ.size());
      errors++;
    end else begin
      for (int i = 0; i < nWrites; i++) begin
        checkAddr($sformatf("%s addr %0d", cmdName[idx], i),
                  sramAddr'(e.start) + sramAddr'(i), writeAddrQ[i]);
        checkWord($sformatf("%s data %0d", cmdName[idx], i),
                  (i < e.size) ? dataQ[i] : `TAG_FINAL, writeDataQ[i]);
      end
    end
  endtask

  initial begin
    rst     = 1'b1;
    rxByte  = '0;
    rxReady = 1'b0;
    rxError = 1'b0;
    txSent  = 1'b0;
    sramAck = 1'b0;
    repeat (2) @(posedge iClock);
    rst <= 1'b0;
    for (int i = 0; i < numCmds; i++) begin
      runCommand(i);
    end
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog/memCtrlTop.sv */
`timescale 1ns/1ps

module memCtrlTop (
  input  logic                 iClock,
  input  logic                 rst,
  input  hostPkg::uartByte     rxByte,
  input  logic                 rxReady,
  input  logic                 rxError,
  output hostPkg::uartByte     txByte,
  output logic                 txReady,
  input  logic                 txSent,
  output sramPkg::sramWriteReq sramReq,
  output logic                 sramWrite,
  input  logic                 sramAck
);
  import hostPkg::*;

  hostWord rxWord;      // assembler to queue
  logic    rxWordValid;
  hostWord fifoWord;    // queue head
  logic    fifoEmpty;
  logic    fifoPop;
  hostWord replyWord;   // writer to serializer
  logic    replyStart;
  logic    txBusy;

  rxWordAssembler rxWordAssembler_inst (
    .iClock, .rst, .rxByte, .rxReady, .rxError, .rxWord, .rxWordValid
  );

  wordFifo wordFifo_inst (
    .iClock, .rst,
    .pushWord (rxWord), .push (rxWordValid),
    .pop (fifoPop), .popWord (fifoWord), .empty (fifoEmpty)
  );

  blockWriter blockWriter_inst (
    .iClock, .rst,
    .word (fifoWord), .empty (fifoEmpty), .pop (fifoPop),
    .sramReq, .sramWrite, .sramAck,
    .replyWord, .replyStart, .txBusy
  );

  txWordSerializer txWordSerializer_inst (
    .iClock, .rst, .replyWord, .replyStart, .txSent, .txByte, .txReady, .txBusy
  );

endmodule

/* verilog/txWordSerializer.sv */
`timescale 1ns/1ps

module txWordSerializer (
  input  logic             iClock,
  input  logic             rst,
  input  hostPkg::hostWord replyWord,
  input  logic             replyStart,
  input  logic             txSent,
  output hostPkg::uartByte txByte,
  output logic             txReady,
  output logic             txBusy
);
  import hostPkg::*;

  uartByte lowByte;    // held until the high byte has left
  logic    lowPending; // high byte out, low byte still to send

  //////////////////////////////
  // high byte first
  //////////////////////////////

  always_ff @(posedge iClock) begin
    if (rst) begin
      txReady    <= 1'b0;
      txBusy     <= 1'b0;
      lowPending <= 1'b0;
    end else begin
      txReady <= 1'b0;
      if (!txBusy) begin
        if (replyStart) begin
          txByte     <= replyWord[15:8];
          lowByte    <= replyWord[7:0];
          txReady    <= 1'b1;
          txBusy     <= 1'b1;
          lowPending <= 1'b1;
        end
      end else if (txSent) begin
        if (lowPending) begin
          txByte     <= lowByte;
          txReady    <= 1'b1;
          lowPending <= 1'b0;
        end else begin
          txBusy <= 1'b0; // second byte gone
        end
      end
    end
  end

endmodule

/* verilog/blockWriter.sv */
`timescale 1ns/1ps

`include "memCtrl_consts.svh"

module blockWriter (
  input  logic                iClock,
  input  logic                rst,
  input  hostPkg::hostWord    word,
  input  logic                empty,
  output logic                pop,
  output sramPkg::sramWriteReq sramReq,
  output logic                sramWrite,
  input  logic                sramAck,
  output hostPkg::hostWord    replyWord,
  output logic                replyStart,
  input  logic                txBusy
);
  import hostPkg::*;
  import sramPkg::*;

  writerState state;
  hostWord    curTag;       // tag of the running command
  sramAddr    size;         // block length in words
  sramAddr    curAddr;
  sramAddr    stopAddr;     // where the closing word belongs
  logic       skipFinal;    // closing word is not stored
  logic       finalPending; // current write is the closing word
  logic       knownTag;
  logic       tagSkip;
  sramAddr    tagSize;
  logic       atStop;

  //////////////////////////////
  // tag decode
  //////////////////////////////

  always_comb begin
    knownTag = 1'b1;
    tagSkip  = 1'b0;
    tagSize  = '0;
    case (word)
      `TAG_REQUEST: tagSize = sramAddr'(`SIZE_INIT);
      `TAG_CAM:     tagSize = sramAddr'(`SIZE_CAM);
      `TAG_OBJ:     tagSize = sramAddr'(`SIZE_OBJ);
      `TAG_VRTX:    tagSize = '0; // set later from the count word
      `TAG_CLS_OBJ: begin
        tagSize = sramAddr'(`SIZE_CLS_OBJ);
        tagSkip = 1'b1;
      end
      `TAG_TMATRIX: begin
        tagSize = sramAddr'(`SIZE_MATRIX);
        tagSkip = 1'b1;
      end
      default:      knownTag = 1'b0; // popped and ignored
    endcase
  end

  // only states that consume a word pop the queue
  always_comb begin
    case (state)
      idle, getCount, getAddress, writeData: pop = !empty;
      default:                               pop = 1'b0;
    endcase
  end

  assign replyStart = ((state == ackTag) || (state == reply)) && !txBusy;
  assign atStop     = (curAddr == stopAddr);

  //////////////////////////////
  // command FSM
  //////////////////////////////

  always_ff @(posedge iClock) begin
    if (rst) begin
      state        <= idle;
      sramWrite    <= 1'b0;
      skipFinal    <= 1'b0;
      finalPending <= 1'b0;
    end else begin
      case (state)
        idle: if (!empty && knownTag) begin
          curTag    <= word;
          replyWord <= ~word; // acknowledge
          size      <= tagSize;
          skipFinal <= tagSkip;
          state     <= ackTag;
        end
        ackTag: if (!txBusy) begin
          state <= (curTag == `TAG_VRTX) ? getCount : getAddress;
        end
        getCount: if (!empty) begin
          size  <= sramAddr'(word) * 22'd3 + 22'd1; // xyz per vertex plus one
          state <= getAddress;
        end
        getAddress: if (!empty) begin
          curAddr  <= sramAddr'(word);
          stopAddr <= sramAddr'(word) + size;
          state    <= writeData;
        end
        writeData: if (!empty) begin
          if (!atStop) begin
            sramReq      <= '{addr: curAddr, data: word};
            sramWrite    <= 1'b1;
            curAddr      <= curAddr + 1'b1;
            finalPending <= 1'b0;
            state        <= waitAck;
          end else if (word == `TAG_FINAL) begin
            replyWord <= curTag; // echo
            if (skipFinal) begin
              state <= reply;
            end else begin
              sramReq      <= '{addr: stopAddr, data: word};
              sramWrite    <= 1'b1;
              finalPending <= 1'b1;
              state        <= waitAck;
            end
          end else begin
            replyWord <= `TAG_ERROR;
            state     <= reply;
          end
        end
        waitAck: if (sramAck) begin
          sramWrite <= 1'b0;
          state     <= finalPending ? reply : writeData;
        end
        reply: if (!txBusy) state <= idle;
        default: state <= idle;
      endcase
    end
  end

endmodule

/* verilog/wordFifo.sv */
`timescale 1ns/1ps

`include "memCtrl_consts.svh"

module wordFifo #(
  parameter int depth = `FIFO_DEPTH
) (
  input  logic             iClock,
  input  logic             rst,
  input  hostPkg::hostWord pushWord,
  input  logic             push,
  input  logic             pop,
  output hostPkg::hostWord popWord,
  output logic             empty
);
  import hostPkg::*;

  localparam int ptrBits = $clog2(depth);
  localparam logic [ptrBits:0] fullCount = (ptrBits + 1)'(depth);

  hostWord            mem [depth]; // no reset on storage
  logic [ptrBits-1:0] rdPtr;
  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits:0]   count;
  logic               doPush;
  logic               doPop;

  assign doPush  = push && (count != fullCount); // full queue loses the word
  assign doPop   = pop && (count != '0);
  assign popWord = mem[rdPtr];
  assign empty   = (count == '0);

  always_ff @(posedge iClock) begin
    if (rst) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1; // wraps, depth is a power of two
      if (doPop) rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge iClock) begin
    if (doPush) mem[wrPtr] <= pushWord;
  end

endmodule

/* verilog/rxWordAssembler.sv */
`timescale 1ns/1ps

module rxWordAssembler (
  input  logic             iClock,
  input  logic             rst,
  input  hostPkg::uartByte rxByte,
  input  logic             rxReady,
  input  logic             rxError,
  output hostPkg::hostWord rxWord,
  output logic             rxWordValid
);
  import hostPkg::*;

  uartByte highByte; // first byte of the pair
  logic    lowPhase; // next byte is the low one

  always_ff @(posedge iClock) begin
    if (rst) begin
      lowPhase    <= 1'b0;
      rxWordValid <= 1'b0;
    end else begin
      rxWordValid <= 1'b0;
      if (rxReady) begin
        if (rxError) begin
          lowPhase <= 1'b0; // drop byte, resync to high
        end else if (!lowPhase) begin
          highByte <= rxByte;
          lowPhase <= 1'b1;
        end else begin
          rxWord      <= {highByte, rxByte};
          rxWordValid <= 1'b1;
          lowPhase    <= 1'b0;
        end
      end
    end
  end

endmodule

/* verilog/sramPkg.sv */
package sramPkg;

  //////////////////////////////
  // memory side
  //////////////////////////////

  typedef logic [21:0] sramAddr; // word address

  // one write request, address in the upper bits
  typedef struct packed {
    sramAddr          addr; // target word
    hostPkg::hostWord data; // value stored there
  } sramWriteReq;

endpackage

/* verilog/hostPkg.sv */
package hostPkg;

  //////////////////////////////
  // uart side
  //////////////////////////////

  typedef logic [7:0]  uartByte; // one byte on the wire
  typedef logic [15:0] hostWord; // command tag or data word

  // block writer FSM
  typedef enum logic [2:0] {
    idle,       // waiting for a tag
    ackTag,     // complemented tag goes back
    getCount,   // vertex count word
    getAddress, // block start address
    writeData,  // data words, then closing word
    waitAck,    // sram write in flight
    reply       // echo or error tag goes back
  } writerState;

endpackage

/* include/memCtrl_consts.svh */
`ifndef MEMCTRL_CONSTS_SVH
`define MEMCTRL_CONSTS_SVH

//////////////////////////////
// command tags
//////////////////////////////

`define TAG_REQUEST 16'hAAAA // init block
`define TAG_CAM     16'hBBBB // camera block
`define TAG_OBJ     16'hEEEE // object header block
`define TAG_VRTX    16'h9999 // vertex block, count word follows
`define TAG_CLS_OBJ 16'h8888 // close object
`define TAG_TMATRIX 16'hABCD // transform matrix

//////////////////////////////
// reply tags
//////////////////////////////

`define TAG_FINAL   16'hFFFF // closing word of every block
`define TAG_ERROR   16'h1414 // closing word was wrong

//////////////////////////////
// block sizes in words
//////////////////////////////

// vertex blocks are sized from the count word instead
`define SIZE_INIT    2
`define SIZE_CAM     5
`define SIZE_OBJ     14
`define SIZE_MATRIX  12
`define SIZE_CLS_OBJ 1

//////////////////////////////
// queue
//////////////////////////////

`define FIFO_DEPTH 4 // words between assembler and writer

`endif
